// File: gx4000_video.f
source/gx4000_video_pkg.sv
source/gx4000_video_ifs.sv
source/asic_register_file.sv
source/palette_fetch.sv
source/sprite_priority.sv
source/colour_mixer.sv
source/gx4000_video.sv
verification/gx4000_video_assertions.sv
verification/gx4000_video_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gx4000_video_tb
FILELIST  ?= gx4000_video.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/gx4000_video_tb.sv
`timescale 1ns/1ns

module gx4000_video_tb;
    import gx4000_video_pkg::*;

    logic        clk_sys;
    logic        reset;
    logic        plus_mode;
    logic        cclk_en_n;
    crtc_addr_t  crtc_ma;
    row_addr_t   crtc_ra;
    logic        crtc_de;
    logic [15:0] cpu_addr;
    reg_byte_t   cpu_data;
    logic        cpu_wr;
    gun_t        r_in, g_in, b_in;
    reg_byte_t   asic_ram_q;
    colour_t     r_out, g_out, b_out;
    logic        sprite_active_out;
    sprite_id_t  sprite_id_out;
    logic        pri_irq;
    crtc_addr_t  asic_ram_addr;
    logic        asic_ram_rd, asic_ram_wr;
    reg_byte_t   asic_ram_din;

    // Reference model state
    reg_byte_t   m_regs [0:7];
    gun_t        m_pal [0:2];
    gun_t        m_prev [0:2];
    colour_t     m_out [0:2];
    logic        m_spr, m_spr_out, m_irq;
    sprite_id_t  m_id, m_id_out;
    reg_byte_t   m_count;

    int          errors;
    int          checks;
    int unsigned de_pct, hit_pct, plus_pct;

    gx4000_video u_dut (.*);

    // ASIC RAM contents are a fixed function of the address
    assign asic_ram_q = asic_ram_addr[7:0] ^ 8'h5A;

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    function automatic reg_byte_t plus_code(int unsigned sel);
        case (sel)
            0: return ASIC_MODE_PALETTE;
            1: return ASIC_MODE_SPRITE_PRI;
            default: return ASIC_MODE_BLEND;
        endcase
    endfunction

    function automatic logic model_enabled();
        return plus_mode && (m_regs[2] == ASIC_MODE_PALETTE
            || m_regs[2] == ASIC_MODE_SPRITE_PRI || m_regs[2] == ASIC_MODE_BLEND);
    endfunction

    function automatic crtc_addr_t model_addr();
        if (model_enabled())
            return {9'd0, crtc_ra[2:0], crtc_ma[1:0]};
        return crtc_ma;
    endfunction

    function automatic logic model_page_wr();
        return cpu_wr && (cpu_addr[15:8] == 8'hBC);
    endfunction

    // Expected colour of one gun while de is high
    function automatic colour_t expect_gun(gun_t pal, gun_t prev, gun_t gun);
        logic [2:0] pal_prev;
        logic [2:0] pal_gun;
        pal_prev = 3'(pal) + 3'(prev);
        pal_gun = 3'(pal) + 3'(gun);
        if (m_regs[0] == 8'h00 || !model_enabled())
            return {2'b00, gun};
        case (m_regs[2])
            ASIC_MODE_PALETTE:
                return (m_regs[1][4:0] == MRER_ENHANCED) ? {2'b00, pal_prev[2:1]} : {2'b00, pal};
            ASIC_MODE_SPRITE_PRI: return m_spr ? {2'b00, pal} : {2'b00, gun};
            ASIC_MODE_BLEND: return {2'b00, pal_gun[2:1]};
            default: return {2'b00, gun};
        endcase
    endfunction

    task automatic model_reset();
        int i;
        for (i = 0; i < 8; i++)
            m_regs[i] = 8'h00;
        for (i = 0; i < 3; i++) begin
            m_pal[i] = 2'b00;
            m_prev[i] = 2'b00;
            m_out[i] = 4'h0;
        end
        m_spr = 1'b0;
        m_spr_out = 1'b0;
        m_irq = 1'b0;
        m_id = 4'h0;
        m_id_out = 4'h0;
        m_count = 8'h00;
    endtask

    // Advance the model by one clock on the inputs of the ending cycle
    task automatic model_clock();
        gun_t       guns [0:2];
        crtc_addr_t addr;
        reg_byte_t  q;
        int         i;
        guns[0] = r_in;
        guns[1] = g_in;
        guns[2] = b_in;
        addr = model_addr();
        q = addr[7:0] ^ 8'h5A;
        if (cclk_en_n) begin
            for (i = 0; i < 3; i++)
                m_out[i] = crtc_de ? expect_gun(m_pal[i], m_prev[i], guns[i]) : 4'h0;
        end
        m_spr_out = m_spr;
        m_id_out = m_id;
        if (cclk_en_n) begin
            m_spr = crtc_de && (crtc_ma[13:10] == SPRITE_PAGE);
            m_id = crtc_de ? crtc_ma[9:6] : 4'h0;
            if (crtc_de && m_regs[4][0]) begin
                if (m_count == m_regs[3])
                    m_irq = 1'b1;
                m_count = m_count + 8'd1;
            end else begin
                m_irq = 1'b0;
                m_count = 8'h00;
            end
            if (crtc_de) begin
                if (plus_mode) begin
                    m_pal[0] = q[1:0];
                    m_pal[1] = q[3:2];
                    m_pal[2] = q[5:4];
                end
                for (i = 0; i < 3; i++)
                    m_prev[i] = guns[i];
            end
        end
        if (model_page_wr() && cpu_addr[2:0] == REG_MRER)
            m_regs[1] = {3'b000, cpu_data[4:0]};
        else if (model_page_wr() && cpu_addr[2:0] < 3'd5)
            m_regs[cpu_addr[2:0]] = cpu_data;
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_cycle(string test);
        check_value({test, " asic_ram_addr"}, 32'(model_addr()), 32'(asic_ram_addr));
        check_value({test, " asic_ram_rd"}, 32'(cclk_en_n && crtc_de && model_enabled()),
                    32'(asic_ram_rd));
        check_value({test, " asic_ram_wr"}, 32'(model_enabled() && model_page_wr()),
                    32'(asic_ram_wr));
        check_value({test, " asic_ram_din"}, 32'(cpu_data), 32'(asic_ram_din));
        check_value({test, " r_out"}, 32'(m_out[0]), 32'(r_out));
        check_value({test, " g_out"}, 32'(m_out[1]), 32'(g_out));
        check_value({test, " b_out"}, 32'(m_out[2]), 32'(b_out));
        check_value({test, " sprite_active_out"}, 32'(m_spr_out), 32'(sprite_active_out));
        check_value({test, " sprite_id_out"}, 32'(m_id_out), 32'(sprite_id_out));
        check_value({test, " pri_irq"}, 32'(m_irq), 32'(pri_irq));
    endtask

    // Update the model, drive new inputs and check at the falling edge
    task automatic step(string test, logic wr, logic [15:0] addr, reg_byte_t data);
        @(posedge clk_sys);
        model_clock();
        #2;
        plus_mode = ($urandom_range(99) < plus_pct);
        cclk_en_n = ($urandom_range(99) < 60);
        crtc_de = ($urandom_range(99) < de_pct);
        crtc_ma = 14'($urandom);
        if ($urandom_range(99) < hit_pct)
            crtc_ma[13:10] = SPRITE_PAGE;
        crtc_ra = 5'($urandom);
        r_in = 2'($urandom);
        g_in = 2'($urandom);
        b_in = 2'($urandom);
        cpu_wr = wr;
        cpu_addr = addr;
        cpu_data = data;
        @(negedge clk_sys);
        check_cycle(test);
    endtask

    task automatic write_reg(string test, logic [2:0] idx, reg_byte_t data);
        step(test, 1'b1, {ASIC_PORT_PAGE, 5'd0, idx}, data);
    endtask

    initial begin
        int unsigned n;
        int unsigned line;
        logic [15:0] addr;
        reg_byte_t   data;
        errors = 0;
        checks = 0;
        de_pct = 80;
        hit_pct = 30;
        plus_pct = 100;
        void'($urandom(32'h6c188c50));
        reset = 1'b1;
        plus_mode = 1'b0;
        cclk_en_n = 1'b0;
        crtc_ma = '0;
        crtc_ra = '0;
        crtc_de = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        cpu_wr = 1'b0;
        r_in = '0;
        g_in = '0;
        b_in = '0;
        model_reset();
        repeat (2) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        @(negedge clk_sys);
        check_cycle("reset");

        // Writes on and off the register page
        plus_pct = 70;
        for (n = 0; n < 200; n++) begin
            addr = {($urandom_range(1) == 1) ? ASIC_PORT_PAGE : 8'($urandom), 5'd0, 3'($urandom)};
            data = ($urandom_range(1) == 1) ? plus_code($urandom_range(2)) : 8'($urandom);
            step("register_page", 1'($urandom), addr, data);
        end

        plus_pct = 100;
        write_reg("standard", REG_ASIC_MODE, ASIC_MODE_BLEND);
        write_reg("standard", REG_CONFIG_MODE, 8'h00);
        repeat (100) step("standard", 1'b0, 16'h0000, 8'h00);
        write_reg("disabled", REG_CONFIG_MODE, 8'h01);
        write_reg("disabled", REG_ASIC_MODE, 8'h00);
        repeat (100) step("disabled", 1'b0, 16'h0000, 8'h00);

        // Every Plus mode with enhanced and plain MRER
        hit_pct = 50;
        for (n = 0; n < 6; n++) begin
            write_reg("plus_modes", REG_ASIC_MODE, plus_code(n / 2));
            data = (n % 2 == 0) ? {3'b000, MRER_ENHANCED} : 8'($urandom_range(31, 2));
            write_reg("plus_modes", REG_MRER, data);
            repeat (60) step("plus_modes", 1'b0, 16'h0000, 8'h00);
        end

        // Priority off until the interrupt left over from earlier phases is gone
        write_reg("priority", REG_PRI_CONTROL, 8'h00);
        n = 0;
        while (pri_irq && n < 100) begin
            step("priority", 1'b0, 16'h0000, 8'h00);
            n++;
        end
        assert (!pri_irq)
        else begin
            errors++;
            $display("pri_irq did not clear within 100 cycles with priority disabled");
        end

        line = $urandom_range(15);
        write_reg("priority", REG_PRI_LINE, 8'(line));
        write_reg("priority", REG_PRI_CONTROL, 8'h01);
        de_pct = 97;
        n = 0;
        while (!pri_irq && n < 500) begin
            step("priority", 1'b0, 16'h0000, 8'h00);
            n++;
        end
        assert (pri_irq)
        else begin
            errors++;
            $display("pri_irq did not rise within 500 cycles for priority line %0d", line);
        end
        de_pct = 50;
        repeat (100) step("priority", 1'b0, 16'h0000, 8'h00);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verification/gx4000_video_assertions.sv
`timescale 1ns/1ns

module gx4000_video_assertions (
    input logic clk_sys, reset, cclk_en, de, cpu_wr, asic_enabled, pri_enable,
    input logic asic_ram_rd, asic_ram_wr, pri_irq, sprite_active_out,
    input gx4000_video_pkg::colour_t    r_out, g_out, b_out,
    input gx4000_video_pkg::sprite_id_t sprite_id_out
);
    // Palette reads only while the ASIC owns the video
    assert property (@(posedge clk_sys) disable iff (reset) asic_ram_rd |-> asic_enabled)
        else $error("asic_ram_rd high while the ASIC is disabled");

    assert property (@(posedge clk_sys) disable iff (reset) asic_ram_wr |-> cpu_wr)
        else $error("asic_ram_wr high without a CPU write");

    // Interrupt drops only on a strobe that ends the priority run
    assert property (@(posedge clk_sys) disable iff (reset)
        $fell(pri_irq) |-> ($past(reset) || $past(cclk_en && !(de && pri_enable))))
        else $error("pri_irq fell without a strobe ending the priority run");

    assert property (@(posedge clk_sys) reset |=> (r_out == '0 && g_out == '0 && b_out == '0
        && !sprite_active_out && sprite_id_out == '0 && !pri_irq && !asic_ram_rd && !asic_ram_wr))
        else $error("outputs not cleared after reset");

endmodule

bind gx4000_video gx4000_video_assertions u_assertions (
    .clk_sys(clk_sys), .reset(reset), .cclk_en(cclk_en_n), .de(crtc_de), .cpu_wr(cpu_wr),
    .asic_enabled(mode.asic_enabled), .pri_enable(mode.pri_enable),
    .asic_ram_rd(asic_ram_rd), .asic_ram_wr(asic_ram_wr), .pri_irq(pri_irq),
    .sprite_active_out(sprite_active_out), .r_out(r_out), .g_out(g_out), .b_out(b_out),
    .sprite_id_out(sprite_id_out)
);

// File: source/gx4000_video.sv
`timescale 1ns/1ns

module gx4000_video (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic                         plus_mode,
    input  logic                         cclk_en_n,
    input  gx4000_video_pkg::crtc_addr_t crtc_ma,
    input  gx4000_video_pkg::row_addr_t  crtc_ra,
    input  logic                         crtc_de,
    input  logic [15:0]                  cpu_addr,
    input  gx4000_video_pkg::reg_byte_t  cpu_data,
    input  logic                         cpu_wr,
    input  gx4000_video_pkg::gun_t       r_in,
    input  gx4000_video_pkg::gun_t       g_in,
    input  gx4000_video_pkg::gun_t       b_in,
    input  gx4000_video_pkg::reg_byte_t  asic_ram_q,
    output gx4000_video_pkg::colour_t    r_out,
    output gx4000_video_pkg::colour_t    g_out,
    output gx4000_video_pkg::colour_t    b_out,
    output logic                         sprite_active_out,
    output gx4000_video_pkg::sprite_id_t sprite_id_out,
    output logic                         pri_irq,
    output gx4000_video_pkg::crtc_addr_t asic_ram_addr,
    output logic                         asic_ram_rd,
    output logic                         asic_ram_wr,
    output gx4000_video_pkg::reg_byte_t  asic_ram_din
);
    import gx4000_video_pkg::*;

    gun_t palette_r;
    gun_t palette_g;
    gun_t palette_b;
    gun_t prev_r;
    gun_t prev_g;
    gun_t prev_b;
    logic sprite_active;

    crtc_beam_if  beam ();
    video_mode_if mode ();

    // Gate Array strobe is active high despite its name
    assign beam.cclk_en = cclk_en_n;
    assign beam.de      = crtc_de;
    assign beam.ma      = crtc_ma;
    assign beam.ra      = crtc_ra;

    asic_register_file u_regs (
        .clk_sys(clk_sys), .reset(reset), .plus_mode(plus_mode),
        .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_wr(cpu_wr), .mode(mode)
    );

    palette_fetch u_palette (
        .clk_sys(clk_sys), .reset(reset), .plus_mode(plus_mode),
        .beam(beam), .mode(mode),
        .cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_wr(cpu_wr),
        .r_in(r_in), .g_in(g_in), .b_in(b_in), .asic_ram_q(asic_ram_q),
        .asic_ram_addr(asic_ram_addr), .asic_ram_rd(asic_ram_rd),
        .asic_ram_wr(asic_ram_wr), .asic_ram_din(asic_ram_din),
        .palette_r(palette_r), .palette_g(palette_g), .palette_b(palette_b),
        .prev_r(prev_r), .prev_g(prev_g), .prev_b(prev_b)
    );

    sprite_priority u_sprite (
        .clk_sys(clk_sys), .reset(reset), .beam(beam), .mode(mode),
        .sprite_active(sprite_active), .sprite_active_out(sprite_active_out),
        .sprite_id_out(sprite_id_out), .pri_irq(pri_irq)
    );

    colour_mixer u_mixer (
        .clk_sys(clk_sys), .reset(reset), .beam(beam), .mode(mode),
        .sprite_active(sprite_active),
        .r_in(r_in), .g_in(g_in), .b_in(b_in),
        .palette_r(palette_r), .palette_g(palette_g), .palette_b(palette_b),
        .prev_r(prev_r), .prev_g(prev_g), .prev_b(prev_b),
        .r_out(r_out), .g_out(g_out), .b_out(b_out)
    );

endmodule

// File: source/colour_mixer.sv
`timescale 1ns/1ns

module colour_mixer (
    input  logic                     clk_sys,
    input  logic                     reset,
    crtc_beam_if.sink                beam,
    video_mode_if.user               mode,
    input  logic                     sprite_active,
    input  gx4000_video_pkg::gun_t   r_in,
    input  gx4000_video_pkg::gun_t   g_in,
    input  gx4000_video_pkg::gun_t   b_in,
    input  gx4000_video_pkg::gun_t   palette_r,
    input  gx4000_video_pkg::gun_t   palette_g,
    input  gx4000_video_pkg::gun_t   palette_b,
    input  gx4000_video_pkg::gun_t   prev_r,
    input  gx4000_video_pkg::gun_t   prev_g,
    input  gx4000_video_pkg::gun_t   prev_b,
    output gx4000_video_pkg::colour_t r_out,
    output gx4000_video_pkg::colour_t g_out,
    output gx4000_video_pkg::colour_t b_out
);
    import gx4000_video_pkg::*;

    logic plus_path;

    // Standard CPC path unless a Plus mode is live
    assign plus_path = (mode.config_mode != 8'h00) && mode.asic_enabled;

    // Mean of two guns, carry kept before the shift
    function automatic colour_t average(input gun_t a, input gun_t b);
        logic [2:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return colour_t'(sum[2:1]);
    endfunction

    // One channel of the mix
    function automatic colour_t mix_gun(input gun_t pal, input gun_t prev, input gun_t gun);
        colour_t result;
        result = colour_t'(gun);
        if (plus_path) begin
            case (mode.asic_mode)
                ASIC_MODE_PALETTE: begin
                    if (mode.mrer_mode == MRER_ENHANCED)
                        result = average(pal, prev);
                    else
                        result = colour_t'(pal);
                end
                ASIC_MODE_SPRITE_PRI: begin
                    // Sprite wins over background
                    if (sprite_active)
                        result = colour_t'(pal);
                end
                ASIC_MODE_BLEND: result = average(pal, gun);
                default: result = colour_t'(gun);
            endcase
        end
        return result;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_out <= '0;
            g_out <= '0;
            b_out <= '0;
        end else if (beam.cclk_en) begin
            if (beam.de) begin
                r_out <= mix_gun(palette_r, prev_r, r_in);
                g_out <= mix_gun(palette_g, prev_g, g_in);
                b_out <= mix_gun(palette_b, prev_b, b_in);
            end else begin
                // Border and blanking are black
                r_out <= '0;
                g_out <= '0;
                b_out <= '0;
            end
        end
    end

endmodule

// File: source/sprite_priority.sv
`timescale 1ns/1ns

module sprite_priority (
    input  logic                          clk_sys,
    input  logic                          reset,
    crtc_beam_if.sink                     beam,
    video_mode_if.user                    mode,
    output logic                          sprite_active,
    output logic                          sprite_active_out,
    output gx4000_video_pkg::sprite_id_t  sprite_id_out,
    output logic                          pri_irq
);
    import gx4000_video_pkg::*;

    sprite_id_t sprite_id;
    reg_byte_t  pri_count;

    // Sprite decode per character, cleared in the border
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sprite_active <= 1'b0;
            sprite_id     <= '0;
        end else if (beam.cclk_en) begin
            if (beam.de) begin
                sprite_active <= (beam.ma[13:10] == SPRITE_PAGE);
                sprite_id     <= beam.ma[9:6];
            end else begin
                sprite_active <= 1'b0;
                sprite_id     <= '0;
            end
        end
    end

    // Free-running one-cycle delay to the outputs
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sprite_active_out <= 1'b0;
            sprite_id_out     <= '0;
        end else begin
            sprite_active_out <= sprite_active;
            sprite_id_out     <= sprite_id;
        end
    end

    // Counts displayed characters; irq holds until de or enable drops
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pri_irq   <= 1'b0;
            pri_count <= '0;
        end else if (beam.cclk_en) begin
            if (beam.de && mode.pri_enable) begin
                if (pri_count == mode.pri_line) begin
                    pri_irq <= 1'b1;
                end
                pri_count <= pri_count + 8'd1;
            end else begin
                pri_irq   <= 1'b0;
                pri_count <= '0;
            end
        end
    end

endmodule

// File: source/palette_fetch.sv
`timescale 1ns/1ns

module palette_fetch (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic                         plus_mode,
    crtc_beam_if.sink                    beam,
    video_mode_if.user                   mode,
    input  logic [15:0]                  cpu_addr,
    input  gx4000_video_pkg::reg_byte_t  cpu_data,
    input  logic                         cpu_wr,
    input  gx4000_video_pkg::gun_t       r_in,
    input  gx4000_video_pkg::gun_t       g_in,
    input  gx4000_video_pkg::gun_t       b_in,
    input  gx4000_video_pkg::reg_byte_t  asic_ram_q,
    output gx4000_video_pkg::crtc_addr_t asic_ram_addr,
    output logic                         asic_ram_rd,
    output logic                         asic_ram_wr,
    output gx4000_video_pkg::reg_byte_t  asic_ram_din,
    output gx4000_video_pkg::gun_t       palette_r,
    output gx4000_video_pkg::gun_t       palette_g,
    output gx4000_video_pkg::gun_t       palette_b,
    output gx4000_video_pkg::gun_t       prev_r,
    output gx4000_video_pkg::gun_t       prev_g,
    output gx4000_video_pkg::gun_t       prev_b
);
    import gx4000_video_pkg::*;

    crtc_addr_t palette_index;

    // Five-bit palette entry from raster line and column
    assign palette_index = crtc_addr_t'({beam.ra[2:0], beam.ma[1:0]});

    assign asic_ram_addr = mode.asic_enabled ? palette_index : beam.ma;
    assign asic_ram_rd   = beam.cclk_en && beam.de && mode.asic_enabled;
    assign asic_ram_wr   = mode.asic_enabled && cpu_wr && (cpu_addr[15:8] == ASIC_PORT_PAGE);
    assign asic_ram_din  = cpu_data;

    // RAM data arrives in the strobe cycle itself
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette_r <= '0;
            palette_g <= '0;
            palette_b <= '0;
            prev_r    <= '0;
            prev_g    <= '0;
            prev_b    <= '0;
        end else if (beam.cclk_en && beam.de) begin
            if (plus_mode) begin
                palette_r <= asic_ram_q[1:0];
                palette_g <= asic_ram_q[3:2];
                palette_b <= asic_ram_q[5:4];
            end
            // Last displayed motherboard colour, for averaging
            prev_r <= r_in;
            prev_g <= g_in;
            prev_b <= b_in;
        end
    end

endmodule

// File: source/asic_register_file.sv
`timescale 1ns/1ns

module asic_register_file (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        plus_mode,
    input  logic [15:0]                 cpu_addr,
    input  gx4000_video_pkg::reg_byte_t cpu_data,
    input  logic                        cpu_wr,
    video_mode_if.owner                 mode
);
    import gx4000_video_pkg::*;

    reg_byte_t config_reg;
    mrer_t     mrer_reg;
    reg_byte_t asic_mode_reg;
    reg_byte_t pri_line_reg;
    reg_byte_t pri_control_reg;
    logic      page_wr;
    logic      plus_code;

    assign page_wr = cpu_wr && (cpu_addr[15:8] == ASIC_PORT_PAGE);

    // Register chosen by the low address bits, not the data
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_reg      <= '0;
            mrer_reg        <= '0;
            asic_mode_reg   <= '0;
            pri_line_reg    <= '0;
            pri_control_reg <= '0;
        end else if (page_wr) begin
            case (cpu_addr[2:0])
                REG_CONFIG_MODE: config_reg <= cpu_data;
                REG_MRER:        mrer_reg <= cpu_data[4:0];
                REG_ASIC_MODE:   asic_mode_reg <= cpu_data;
                REG_PRI_LINE:    pri_line_reg <= cpu_data;
                REG_PRI_CONTROL: pri_control_reg <= cpu_data;
                default: begin
                    // Indices 5 to 7 are not implemented
                end
            endcase
        end
    end

    // Only the three Plus codes hand video over to the ASIC
    assign plus_code = (asic_mode_reg == ASIC_MODE_PALETTE)
                    || (asic_mode_reg == ASIC_MODE_SPRITE_PRI)
                    || (asic_mode_reg == ASIC_MODE_BLEND);

    // Live level, follows plus_mode without a rewrite
    assign mode.asic_enabled = plus_code && plus_mode;

    assign mode.config_mode = config_reg;
    assign mode.mrer_mode   = mrer_reg;
    assign mode.asic_mode   = asic_mode_reg;
    assign mode.pri_line    = pri_line_reg;
    assign mode.pri_enable  = pri_control_reg[0];

endmodule

// File: source/gx4000_video_ifs.sv
`timescale 1ns/1ns

// Beam position and character strobe from the CRTC side
interface crtc_beam_if;
    import gx4000_video_pkg::*;

    logic       cclk_en;
    logic       de;
    crtc_addr_t ma;
    row_addr_t  ra;

    modport sink (input cclk_en, de, ma, ra);
endinterface

// Mode registers as seen by the video datapath
interface video_mode_if;
    import gx4000_video_pkg::*;

    reg_byte_t config_mode;
    mrer_t     mrer_mode;
    reg_byte_t asic_mode;
    logic      asic_enabled;
    reg_byte_t pri_line;
    logic      pri_enable;

    modport owner (output config_mode, mrer_mode, asic_mode, asic_enabled, pri_line, pri_enable);
    modport user (input config_mode, mrer_mode, asic_mode, asic_enabled, pri_line, pri_enable);
endinterface

// File: source/gx4000_video_pkg.sv
package gx4000_video_pkg;

    // Widths with a meaning of their own
    typedef logic [3:0]  colour_t;
    typedef logic [1:0]  gun_t;
    typedef logic [13:0] crtc_addr_t;
    typedef logic [4:0]  row_addr_t;
    typedef logic [7:0]  reg_byte_t;
    typedef logic [4:0]  mrer_t;
    typedef logic [3:0]  sprite_id_t;

    // Upper address byte of the CPU register page
    localparam logic [7:0] ASIC_PORT_PAGE = 8'hBC;

    // Register index, taken from cpu_addr[2:0]
    localparam logic [2:0] REG_CONFIG_MODE = 3'd0;
    localparam logic [2:0] REG_MRER        = 3'd1;
    localparam logic [2:0] REG_ASIC_MODE   = 3'd2;
    localparam logic [2:0] REG_PRI_LINE    = 3'd3;
    localparam logic [2:0] REG_PRI_CONTROL = 3'd4;

    // Plus video modes
    localparam reg_byte_t ASIC_MODE_PALETTE    = 8'h02;
    localparam reg_byte_t ASIC_MODE_SPRITE_PRI = 8'h62;
    localparam reg_byte_t ASIC_MODE_BLEND      = 8'h82;

    // MRER value that turns on palette averaging
    localparam mrer_t MRER_ENHANCED = 5'h01;

    // CRTC address bits 13:10 of a sprite character
    localparam logic [3:0] SPRITE_PAGE = 4'hF;

endpackage
